// File: Bender.yml
package:
  name: div_pipeline

sources:
  - hw/div_pkg.sv
  - hw/div_operand_prep.sv
  - hw/div_stage.sv
  - hw/div_result_fmt.sv
  - hw/div_pipeline.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/div_pipeline_asserts.sv
      - test/tb_div_pipeline.sv

// File: flist.f
+incdir+test
hw/div_pkg.sv
hw/div_operand_prep.sv
hw/div_stage.sv
hw/div_result_fmt.sv
hw/div_pipeline.sv
test/div_pipeline_asserts.sv
test/tb_div_pipeline.sv

// File: hw/div_operand_prep.sv
// Divider operand preparation

`timescale 1ns/1ps

module div_operand_prep #(
    parameter int unsigned DATA_W   = div_pkg::XLEN,
    parameter int unsigned TAG_BITS = div_pkg::TAG_W
) (
    input  logic                clk_i,
    input  logic                rstn_i,
    input  logic                kill_i,
    input  logic                valid_i,
    input  logic                signed_i,
    input  logic                rem_i,
    input  logic                word_i,
    input  logic [TAG_BITS-1:0] tag_i,
    input  logic [DATA_W-1:0]   src1_i,    // Dividend
    input  logic [DATA_W-1:0]   src2_i,    // Divisor
    output logic                valid_o,
    output logic                signed_o,
    output logic                rem_o,
    output logic                word_o,
    output logic                div_zero_o,
    output logic                quo_neg_o,
    output logic                rem_neg_o,
    output logic [TAG_BITS-1:0] tag_o,
    output logic [DATA_W-1:0]   dividend_o,
    output logic [DATA_W-1:0]   rem_acc_o,
    output logic [DATA_W-1:0]   dq_o,
    output logic [DATA_W-1:0]   divisor_o
);

    localparam int unsigned HALF_W = DATA_W / 2;

    logic              src1_sign;
    logic              src2_sign;
    logic              src1_neg;
    logic              src2_neg;
    logic              src2_zero;
    logic [DATA_W-1:0] src1_abs;
    logic [DATA_W-1:0] src2_abs;
    logic [DATA_W-1:0] dq_init;
    logic [DATA_W-1:0] divisor_init;

    // ----------------------------------------
    // Signs and magnitudes
    // ----------------------------------------

    // Word operations look at bit 31 only
    assign src1_sign = word_i ? src1_i[HALF_W-1] : src1_i[DATA_W-1];
    assign src2_sign = word_i ? src2_i[HALF_W-1] : src2_i[DATA_W-1];

    assign src1_neg = signed_i & src1_sign;
    assign src2_neg = signed_i & src2_sign;

    // Low half of the negation is also the word negation
    assign src1_abs = src1_neg ? (~src1_i + 1'b1) : src1_i;
    assign src2_abs = src2_neg ? (~src2_i + 1'b1) : src2_i;

    assign src2_zero = word_i ? ~(|src2_i[HALF_W-1:0]) : ~(|src2_i);

    // A word dividend sits in the upper half so that half the steps finish it
    assign dq_init = word_i ? {src1_abs[HALF_W-1:0], {HALF_W{1'b0}}} : src1_abs;

    assign divisor_init = word_i ? {{HALF_W{1'b0}}, src2_abs[HALF_W-1:0]} : src2_abs;

    // ----------------------------------------
    // Pipeline entry
    // ----------------------------------------

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= valid_i & ~kill_i;  // Killed issue is dropped
        end
    end

    always_ff @(posedge clk_i) begin
        if (valid_i) begin
            signed_o   <= signed_i;
            rem_o      <= rem_i;
            word_o     <= word_i;
            tag_o      <= tag_i;
            div_zero_o <= src2_zero;
            // Sign of the quotient is moot when dividing by zero
            quo_neg_o  <= (src1_neg ^ src2_neg) & ~src2_zero;
            rem_neg_o  <= src1_neg;           // Remainder follows the dividend
            dividend_o <= src1_i;
            rem_acc_o  <= '0;
            dq_o       <= dq_init;
            divisor_o  <= divisor_init;
        end
    end

endmodule

// File: hw/div_pipeline.sv
// Pipelined integer divider

`timescale 1ns/1ps

module div_pipeline #(
    parameter int unsigned DATA_W   = div_pkg::XLEN,
    parameter int unsigned TAG_BITS = div_pkg::TAG_W
) (
    input  logic                clk_i,
    input  logic                rstn_i,
    input  logic                kill_i,    // Flushes every stage
    input  logic                valid_i,
    input  logic                signed_i,
    input  logic                rem_i,     // Remainder instead of quotient
    input  logic                word_i,    // 32-bit operation
    input  logic [TAG_BITS-1:0] tag_i,
    input  logic [DATA_W-1:0]   src1_i,
    input  logic [DATA_W-1:0]   src2_i,
    output logic                valid_o,
    output logic [TAG_BITS-1:0] tag_o,
    output logic [DATA_W-1:0]   result_o
);

    localparam int unsigned N_ST = DATA_W / 2;

    // Index 0 is the preparation output, index n+1 the output of stage n
    logic                valid_p    [N_ST+1];
    logic                signed_p   [N_ST+1];
    logic                rem_p      [N_ST+1];
    logic                word_p     [N_ST+1];
    logic                div_zero_p [N_ST+1];
    logic                quo_neg_p  [N_ST+1];
    logic                rem_neg_p  [N_ST+1];
    logic [TAG_BITS-1:0] tag_p      [N_ST+1];
    logic [DATA_W-1:0]   dividend_p [N_ST+1];
    logic [DATA_W-1:0]   rem_acc_p  [N_ST+1];
    logic [DATA_W-1:0]   dq_p       [N_ST+1];
    logic [DATA_W-1:0]   divisor_p  [N_ST+1];

    div_operand_prep #(
        .DATA_W   (DATA_W),
        .TAG_BITS (TAG_BITS)
    ) u_prep (
        .clk_i      (clk_i),
        .rstn_i     (rstn_i),
        .kill_i     (kill_i),
        .valid_i    (valid_i),
        .signed_i   (signed_i),
        .rem_i      (rem_i),
        .word_i     (word_i),
        .tag_i      (tag_i),
        .src1_i     (src1_i),
        .src2_i     (src2_i),
        .valid_o    (valid_p[0]),
        .signed_o   (signed_p[0]),
        .rem_o      (rem_p[0]),
        .word_o     (word_p[0]),
        .div_zero_o (div_zero_p[0]),
        .quo_neg_o  (quo_neg_p[0]),
        .rem_neg_o  (rem_neg_p[0]),
        .tag_o      (tag_p[0]),
        .dividend_o (dividend_p[0]),
        .rem_acc_o  (rem_acc_p[0]),
        .dq_o       (dq_p[0]),
        .divisor_o  (divisor_p[0])
    );

    // ----------------------------------------
    // Division stages
    // ----------------------------------------

    for (genvar n = 0; n < N_ST; n++) begin : g_stage
        div_stage #(
            .DATA_W    (DATA_W),
            .TAG_BITS  (TAG_BITS),
            .STAGE_IDX (n)
        ) u_stage (
            .clk_i      (clk_i),
            .rstn_i     (rstn_i),
            .kill_i     (kill_i),
            .valid_i    (valid_p[n]),
            .signed_i   (signed_p[n]),
            .rem_i      (rem_p[n]),
            .word_i     (word_p[n]),
            .div_zero_i (div_zero_p[n]),
            .quo_neg_i  (quo_neg_p[n]),
            .rem_neg_i  (rem_neg_p[n]),
            .tag_i      (tag_p[n]),
            .dividend_i (dividend_p[n]),
            .rem_acc_i  (rem_acc_p[n]),
            .dq_i       (dq_p[n]),
            .divisor_i  (divisor_p[n]),
            .valid_o    (valid_p[n+1]),
            .signed_o   (signed_p[n+1]),
            .rem_o      (rem_p[n+1]),
            .word_o     (word_p[n+1]),
            .div_zero_o (div_zero_p[n+1]),
            .quo_neg_o  (quo_neg_p[n+1]),
            .rem_neg_o  (rem_neg_p[n+1]),
            .tag_o      (tag_p[n+1]),
            .dividend_o (dividend_p[n+1]),
            .rem_acc_o  (rem_acc_p[n+1]),
            .dq_o       (dq_p[n+1]),
            .divisor_o  (divisor_p[n+1])
        );
    end

    // Divisor of the last stage is not needed by the formatter
    div_result_fmt #(
        .DATA_W   (DATA_W),
        .TAG_BITS (TAG_BITS)
    ) u_fmt (
        .valid_i    (valid_p[N_ST]),
        .signed_i   (signed_p[N_ST]),
        .rem_i      (rem_p[N_ST]),
        .word_i     (word_p[N_ST]),
        .div_zero_i (div_zero_p[N_ST]),
        .quo_neg_i  (quo_neg_p[N_ST]),
        .rem_neg_i  (rem_neg_p[N_ST]),
        .tag_i      (tag_p[N_ST]),
        .dividend_i (dividend_p[N_ST]),
        .rem_acc_i  (rem_acc_p[N_ST]),
        .dq_i       (dq_p[N_ST]),
        .valid_o    (valid_o),
        .tag_o      (tag_o),
        .result_o   (result_o)
    );

endmodule

// File: hw/div_pkg.sv
// Divider shared definitions

package div_pkg;

    // ----------------------------------------
    // Widths
    // ----------------------------------------

    // Operand and result width
    parameter int unsigned XLEN = 64;

    // Two quotient bits are resolved per stage
    parameter int unsigned NUM_STAGES = XLEN / 2;

    // Operation tag carried next to the data
    parameter int unsigned TAG_W = 5;

    // Enough bits to count the stages
    parameter int unsigned STAGE_W = $clog2(NUM_STAGES);

    // ----------------------------------------
    // Vector types
    // ----------------------------------------

    // Operands, remainders and results
    typedef logic [XLEN-1:0] xlen_t;

    // Identifies one operation in flight
    typedef logic [TAG_W-1:0] tag_t;

    // Index of a pipeline stage
    typedef logic [STAGE_W-1:0] stage_cnt_t;

endpackage

// File: hw/div_result_fmt.sv
// Divider result formatting

`timescale 1ns/1ps

module div_result_fmt #(
    parameter int unsigned DATA_W   = div_pkg::XLEN,
    parameter int unsigned TAG_BITS = div_pkg::TAG_W
) (
    input  logic                valid_i,
    input  logic                signed_i,
    input  logic                rem_i,
    input  logic                word_i,
    input  logic                div_zero_i,
    input  logic                quo_neg_i,
    input  logic                rem_neg_i,
    input  logic [TAG_BITS-1:0] tag_i,
    input  logic [DATA_W-1:0]   dividend_i,
    input  logic [DATA_W-1:0]   rem_acc_i,
    input  logic [DATA_W-1:0]   dq_i,
    output logic                valid_o,
    output logic [TAG_BITS-1:0] tag_o,
    output logic [DATA_W-1:0]   result_o
);

    localparam int unsigned HALF_W = DATA_W / 2;

    logic              negate_quo;
    logic              negate_rem;
    logic [DATA_W-1:0] quo_signed;
    logic [DATA_W-1:0] rem_signed;
    logic [DATA_W-1:0] quo_final;
    logic [DATA_W-1:0] rem_final;
    logic [DATA_W-1:0] selected;
    logic [DATA_W-1:0] extended;

    // ----------------------------------------
    // Sign restore
    // ----------------------------------------

    assign negate_quo = signed_i & quo_neg_i;
    assign negate_rem = signed_i & rem_neg_i;

    assign quo_signed = negate_quo ? (~dq_i + 1'b1) : dq_i;
    assign rem_signed = negate_rem ? (~rem_acc_i + 1'b1) : rem_acc_i;

    // MIN / -1 needs no special path, the negated magnitude wraps to MIN

    // ----------------------------------------
    // Special cases and selection
    // ----------------------------------------

    // Division by zero: all ones and the dividend
    assign quo_final = div_zero_i ? '1 : quo_signed;
    assign rem_final = div_zero_i ? dividend_i : rem_signed;

    assign selected = rem_i ? rem_final : quo_final;

    // Word results come from the low half, sign-extended
    assign extended = word_i ? {{HALF_W{selected[HALF_W-1]}}, selected[HALF_W-1:0]}
                             : selected;

    // Idle output stays at zero
    assign valid_o  = valid_i;
    assign tag_o    = valid_i ? tag_i : '0;
    assign result_o = valid_i ? extended : '0;

endmodule

// File: hw/div_stage.sv
// Two-bit restoring division stage

`timescale 1ns/1ps

module div_stage #(
    parameter int unsigned DATA_W    = div_pkg::XLEN,
    parameter int unsigned TAG_BITS  = div_pkg::TAG_W,
    parameter int unsigned STAGE_IDX = 0
) (
    input  logic                clk_i,
    input  logic                rstn_i,
    input  logic                kill_i,
    input  logic                valid_i,
    input  logic                signed_i,
    input  logic                rem_i,
    input  logic                word_i,
    input  logic                div_zero_i,
    input  logic                quo_neg_i,
    input  logic                rem_neg_i,
    input  logic [TAG_BITS-1:0] tag_i,
    input  logic [DATA_W-1:0]   dividend_i,
    input  logic [DATA_W-1:0]   rem_acc_i,
    input  logic [DATA_W-1:0]   dq_i,
    input  logic [DATA_W-1:0]   divisor_i,
    output logic                valid_o,
    output logic                signed_o,
    output logic                rem_o,
    output logic                word_o,
    output logic                div_zero_o,
    output logic                quo_neg_o,
    output logic                rem_neg_o,
    output logic [TAG_BITS-1:0] tag_o,
    output logic [DATA_W-1:0]   dividend_o,
    output logic [DATA_W-1:0]   rem_acc_o,
    output logic [DATA_W-1:0]   dq_o,
    output logic [DATA_W-1:0]   divisor_o
);

    // Word quotients are complete once the first half of the stages is done
    localparam bit WORD_HOLD = (STAGE_IDX >= DATA_W / 4);

    logic [2*DATA_W-1:0] step_a;  // {remainder, dq} after the first step
    logic [2*DATA_W-1:0] step_b;
    logic                hold;

    // One restoring step, returns {remainder, dq}
    function automatic logic [2*DATA_W-1:0] div_step(input logic [DATA_W-1:0] rem,
                                                     input logic [DATA_W-1:0] dq,
                                                     input logic [DATA_W-1:0] dvs);
        logic [DATA_W:0] rem_sh;
        logic [DATA_W:0] diff;
        rem_sh = {rem, dq[DATA_W-1]};
        diff   = rem_sh - {1'b0, dvs};
        if (!diff[DATA_W]) begin
            div_step = {diff[DATA_W-1:0], dq[DATA_W-2:0], 1'b1};
        end else begin
            div_step = {rem_sh[DATA_W-1:0], dq[DATA_W-2:0], 1'b0};
        end
    endfunction

    assign step_a = div_step(rem_acc_i, dq_i, divisor_i);
    assign step_b = div_step(step_a[2*DATA_W-1:DATA_W], step_a[DATA_W-1:0], divisor_i);

    assign hold = WORD_HOLD & word_i;

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= valid_i & ~kill_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (valid_i) begin
            signed_o   <= signed_i;
            rem_o      <= rem_i;
            word_o     <= word_i;
            div_zero_o <= div_zero_i;
            quo_neg_o  <= quo_neg_i;
            rem_neg_o  <= rem_neg_i;
            tag_o      <= tag_i;
            dividend_o <= dividend_i;
            divisor_o  <= divisor_i;
            // Pass-through for finished word operations
            rem_acc_o  <= hold ? rem_acc_i : step_b[2*DATA_W-1:DATA_W];
            dq_o       <= hold ? dq_i : step_b[DATA_W-1:0];
        end
    end

endmodule

// File: test/div_pipeline_asserts.sv
// Divider pipeline assertions

`timescale 1ns/1ps

module div_pipeline_asserts #(
    parameter int unsigned DATA_W = div_pkg::XLEN
) (
    input logic clk_i,
    input logic rstn_i,
    input logic kill_i,
    input logic valid_i,
    input logic valid_o
);

    localparam int unsigned LAT = DATA_W / 2 + 1;  // Preparation plus all stages

    int unsigned fail_cnt = 0;  // Number of failed assertions

    reset_idle: assert property (@(posedge clk_i) !rstn_i |-> !valid_o)
        else begin
            $error("valid_o high while reset is held");
            fail_cnt++;
        end

    // Every result needs an accepted issue exactly LAT cycles before
    fixed_latency: assert property (@(posedge clk_i) disable iff (!rstn_i)
        valid_o |-> $past(valid_i && !kill_i, LAT))
        else begin
            $error("valid_o without a matching issue");
            fail_cnt++;
        end

    kill_flush: assert property (@(posedge clk_i) disable iff (!rstn_i)
        kill_i |=> !valid_o)
        else begin
            $error("valid_o high right after a kill");
            fail_cnt++;
        end

endmodule

bind div_pipeline div_pipeline_asserts #(.DATA_W(DATA_W)) u_asserts (
    .clk_i   (clk_i),
    .rstn_i  (rstn_i),
    .kill_i  (kill_i),
    .valid_i (valid_i),
    .valid_o (valid_o)
);

// File: test/div_ref_model.svh
// Divider reference model

`ifndef DIV_REF_MODEL_SVH
`define DIV_REF_MODEL_SVH

// RISC-V division rules, quotient or remainder picked by is_rem
function automatic div_pkg::xlen_t ref_div(input logic is_signed, input logic is_rem,
                                           input logic is_word, input div_pkg::xlen_t a,
                                           input div_pkg::xlen_t b);
    logic [63:0] q;
    logic [63:0] r;
    logic [31:0] qw;
    logic [31:0] rw;
    if (is_word) begin
        if (b[31:0] == 32'd0) begin
            qw = '1;
            rw = a[31:0];
        end else if (is_signed && a[31:0] == 32'h8000_0000 && b[31:0] == '1) begin
            qw = 32'h8000_0000;  // Overflow returns the dividend
            rw = '0;
        end else if (is_signed) begin
            qw = $signed(a[31:0]) / $signed(b[31:0]);
            rw = $signed(a[31:0]) % $signed(b[31:0]);  // Sign of the dividend
        end else begin
            qw = a[31:0] / b[31:0];
            rw = a[31:0] % b[31:0];
        end
        q = {{32{qw[31]}}, qw};
        r = {{32{rw[31]}}, rw};
    end else if (b == 64'd0) begin
        q = '1;
        r = a;
    end else if (is_signed && a == 64'h8000_0000_0000_0000 && b == '1) begin
        q = a;
        r = '0;
    end else if (is_signed) begin
        q = $signed(a) / $signed(b);
        r = $signed(a) % $signed(b);
    end else begin
        q = a / b;
        r = a % b;
    end
    return is_rem ? r : q;
endfunction

`endif

// File: test/tb_div_pipeline.sv
// Divider pipeline testbench

`timescale 1ns/1ps

module tb_div_pipeline;

    localparam int unsigned LAT = div_pkg::NUM_STAGES + 1;

    logic           clk_i;
    logic           rstn_i;
    logic           kill_i;
    logic           valid_i;
    logic           signed_i;
    logic           rem_i;
    logic           word_i;
    div_pkg::tag_t  tag_i;
    div_pkg::xlen_t src1_i;
    div_pkg::xlen_t src2_i;
    logic           valid_o;
    div_pkg::tag_t  tag_o;
    div_pkg::xlen_t result_o;

    integer         seed;
    int unsigned    cyc;
    int unsigned    checks;
    int unsigned    errors;
    div_pkg::tag_t  next_tag;
    div_pkg::tag_t  exp_tag[$];   // Outstanding operations with the oldest first
    div_pkg::xlen_t exp_res[$];
    int unsigned    exp_cyc[$];   // Cycle in which the result must show

    `include "div_ref_model.svh"

    div_pipeline DUT (.*);

    always #50 clk_i = ~clk_i;

    always @(posedge clk_i) begin
        cyc <= cyc + 1;
    end

    // ----------------------------------------
    // Result checker
    // ----------------------------------------

    always @(negedge clk_i) begin
        if (rstn_i && valid_o) begin
            checks++;
            if (exp_tag.size() == 0) begin
                errors++;
                $display("Result at %0t arrived with no operation outstanding", $time);
            end else begin
                if (tag_o !== exp_tag[0] || result_o !== exp_res[0] || cyc != exp_cyc[0]) begin
                    errors++;
                    $display("Error at %0t: tag %0d result %h cycle %0d, expected %0d %h %0d",
                             $time, tag_o, result_o, cyc, exp_tag[0], exp_res[0], exp_cyc[0]);
                end
                void'(exp_tag.pop_front());
                void'(exp_res.pop_front());
                void'(exp_cyc.pop_front());
            end
        end else if (rstn_i && (tag_o !== '0 || result_o !== '0)) begin
            errors++;
            $display("Error at %0t: idle outputs not zero", $time);
        end
    end

    function automatic div_pkg::xlen_t rand64();
        return {$random(seed), $random(seed)};
    endfunction

    task automatic issue(input logic s, input logic r, input logic w,
                         input div_pkg::xlen_t a, input div_pkg::xlen_t b);
        @(posedge clk_i);
        #1;
        {valid_i, kill_i} = 2'b10;
        {signed_i, rem_i, word_i} = {s, r, w};
        {src1_i, src2_i} = {a, b};
        tag_i = next_tag;
        exp_tag.push_back(next_tag);
        exp_res.push_back(ref_div(s, r, w, a, b));
        exp_cyc.push_back(cyc + LAT);
        next_tag++;
    endtask

    task automatic issue_random();
        logic [2:0]     kind;
        div_pkg::xlen_t b;
        kind = 3'($random(seed));
        b = rand64() >> ($unsigned($random(seed)) % 64);  // Spread of divisor sizes
        if ($unsigned($random(seed)) % 16 == 0) begin
            b = '0;
        end
        issue(kind[0], kind[1], kind[2], rand64(), b);
    endtask

    // Kill with one more issue in the same cycle
    task automatic kill_pipe();
        @(posedge clk_i);
        #1;
        {valid_i, kill_i} = 2'b11;
        tag_i = next_tag;
        src1_i = rand64();
        next_tag++;
        while (exp_cyc.size() != 0 && exp_cyc[$] > cyc) begin
            void'(exp_tag.pop_back());
            void'(exp_res.pop_back());
            void'(exp_cyc.pop_back());
        end
    endtask

    task automatic drain();
        int unsigned n;
        @(posedge clk_i);
        #1;
        {valid_i, kill_i} = 2'b00;
        n = 0;
        while (exp_tag.size() != 0 && n < LAT + 8) begin
            @(posedge clk_i);
            n++;
        end
        if (exp_tag.size() != 0) begin
            $display("Timeout with %0d results still missing", exp_tag.size());
            $display("Simulation failed");
            $finish;
        end
    endtask

    task automatic report_test(input string name, input int unsigned err0);
        $display("Test %s finished with %0d errors", name, errors - err0);
    endtask

    // ----------------------------------------
    // Stimulus
    // ----------------------------------------

    initial begin
        int unsigned    err0;
        div_pkg::xlen_t a;
        div_pkg::xlen_t b;
        {clk_i, rstn_i, kill_i, valid_i, signed_i, rem_i, word_i} = 7'b0100000;
        {tag_i, src1_i, src2_i} = '0;
        {seed, cyc, checks, errors, next_tag} = {32'hb120, 96'd0, 5'd0};
        #10;
        rstn_i = 1'b0;
        repeat (8) @(posedge clk_i);
        #1;
        rstn_i = 1'b1;

        err0 = errors;
        for (int i = 0; i < 4; i++) begin
            a = i[0] ? -64'd1000 : 64'd1000;
            b = i[1] ? -64'd7 : 64'd7;
            for (int k = 0; k < 4; k++) begin
                issue(k[0], k[1], 1'b0, a, b);
            end
        end
        issue(1'b0, 1'b0, 1'b0, 64'hffff_ffff_ffff_fff1, 64'h0000_0001_0000_0003);
        drain();
        report_test("basic division", err0);

        err0 = errors;
        for (int i = 0; i < 24; i++) begin
            b = rand64();
            b[31:0] = b[31:0] >> ($unsigned($random(seed)) % 28);  // Upper half stays random
            issue(i[0], i[1], 1'b1, rand64(), b);
        end
        drain();
        report_test("word operations", err0);

        err0 = errors;
        for (int i = 0; i < 8; i++) begin
            b = i[2] ? (rand64() & 64'hffff_ffff_0000_0000) : '0;
            issue(i[0], i[1], i[2], rand64(), b);
        end
        for (int k = 0; k < 2; k++) begin
            issue(1'b1, k[0], 1'b0, 64'h8000_0000_0000_0000, '1);
            issue(1'b1, k[0], 1'b1, 64'h1234_5678_8000_0000, 64'h0000_0000_ffff_ffff);
        end
        drain();
        report_test("special cases", err0);

        err0 = errors;
        for (int i = 0; i < 200; i++) begin
            issue_random();
        end
        drain();
        report_test("throughput and ordering", err0);

        err0 = errors;
        for (int i = 0; i < 20; i++) begin
            issue_random();
        end
        kill_pipe();
        for (int i = 0; i < 20; i++) begin
            issue_random();
        end
        drain();
        repeat (LAT + 4) @(posedge clk_i);  // Room for stray results to show
        report_test("kill", err0);

        errors = errors + DUT.u_asserts.fail_cnt;
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0 && checks > 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule
